//--- build.f
+incdir+sim
common/bp_config_pkg.sv
common/bp_types_pkg.sv
local_predictor/local_history_table.sv
local_predictor/pattern_counter_table.sv
local_predictor/resolve_update.sv
hdl/branch_predictor.sv
sim/tb_branch_predictor.sv

//--- common/bp_config_pkg.sv
package bp_config_pkg;

	// sizing of the two-level local predictor

	localparam int NUM_SLOTS = 2; // fetch and resolve slots per cycle, slot 0 oldest

	localparam int PC_WIDTH = 64; // full program counter
	localparam int PC_OFFSET_BITS = 2; // word aligned, low bits skipped for indexing

	// first level, per-branch local histories
	localparam int LHT_INDEX_BITS = 4; // pc[LHT_INDEX_BITS+1:2]
	localparam int LHT_ENTRIES = 1 << LHT_INDEX_BITS; // 16 histories

	// second level, pattern history counters
	localparam int HIST_BITS = 6; // one local history, also the counter index
	localparam int PHT_ENTRIES = 1 << HIST_BITS; // 64 counters

	localparam int COUNTER_BITS = 2; // 2-bit saturating counter

endpackage

//--- common/bp_types_pkg.sv
package bp_types_pkg;

	import bp_config_pkg::*;

	// msb of the value is the predicted direction
	typedef enum logic [COUNTER_BITS-1:0] {
		STRONG_NT = 2'b00,
		WEAK_NT   = 2'b01,
		WEAK_T    = 2'b10,
		STRONG_T  = 2'b11
	} counter_state_e;

	typedef struct packed {
		logic                valid; // fetch slot holds an instruction
		logic [PC_WIDTH-1:0] pc;
	} fetch_slot_t;

	typedef struct packed {
		logic                valid; // branch resolved this cycle
		logic [PC_WIDTH-1:0] pc;
		logic                taken; // real outcome
	} resolve_slot_t;

	typedef struct packed {
		logic valid;
		logic taken; // predicted direction
	} prediction_t;

	typedef struct packed {
		logic valid;
		logic mispredict; // stored counter disagreed with the outcome
	} mispredict_t;

	// one write into the counter table
	typedef struct packed {
		logic                 en;
		logic [HIST_BITS-1:0] index;
		counter_state_e       state;
	} counter_write_t;

endpackage

//--- hdl/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor
	import bp_config_pkg::*, bp_types_pkg::*;
(
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          predictor_enable, // gates fetch side only
	input  fetch_slot_t   [NUM_SLOTS-1:0] fetch,
	input  resolve_slot_t [NUM_SLOTS-1:0] resolve,
	output prediction_t   [NUM_SLOTS-1:0] prediction,
	output mispredict_t   [NUM_SLOTS-1:0] mispredict
);

	logic [NUM_SLOTS-1:0][PC_WIDTH-1:0] fetch_pc;
	logic [NUM_SLOTS-1:0][HIST_BITS-1:0] fetch_history; // counter index per fetch
	logic [NUM_SLOTS-1:0][HIST_BITS-1:0] resolve_history; // counter index per resolve
	counter_state_e [NUM_SLOTS-1:0] fetch_state;
	counter_state_e [NUM_SLOTS-1:0] resolve_state;
	counter_write_t [NUM_SLOTS-1:0] counter_write;

	always_comb begin
		for (int i = 0; i < NUM_SLOTS; i++) begin
			fetch_pc[i] = fetch[i].pc;
		end
	end

	// level 1, pc -> local history
	local_history_table u_local_history_table (
		.clock           (clock),
		.reset           (reset),
		.fetch_pc        (fetch_pc),
		.resolve         (resolve),
		.fetch_history   (fetch_history),
		.resolve_history (resolve_history)
	);

	// level 2, history -> counter
	pattern_counter_table u_pattern_counter_table (
		.clock         (clock),
		.reset         (reset),
		.fetch_index   (fetch_history),
		.resolve_index (resolve_history),
		.counter_write (counter_write),
		.fetch_state   (fetch_state),
		.resolve_state (resolve_state)
	);

	// training and mispredict flags
	resolve_update u_resolve_update (
		.resolve         (resolve),
		.resolve_history (resolve_history),
		.resolve_state   (resolve_state),
		.counter_write   (counter_write),
		.mispredict      (mispredict)
	);

	// enable low forces both valid and taken to 0
	always_comb begin
		for (int i = 0; i < NUM_SLOTS; i++) begin
			prediction[i].valid = predictor_enable && fetch[i].valid;
			prediction[i].taken = predictor_enable && fetch[i].valid &&
				fetch_state[i][COUNTER_BITS-1]; // msb is direction
		end
	end

endmodule

//--- local_predictor/local_history_table.sv
`timescale 1ns/1ps

module local_history_table
	import bp_config_pkg::*, bp_types_pkg::*;
(
	input  logic                                  clock,
	input  logic                                  reset,
	input  logic          [NUM_SLOTS-1:0][PC_WIDTH-1:0]  fetch_pc,
	input  resolve_slot_t [NUM_SLOTS-1:0]                resolve,
	output logic          [NUM_SLOTS-1:0][HIST_BITS-1:0] fetch_history,
	output logic          [NUM_SLOTS-1:0][HIST_BITS-1:0] resolve_history
);

	logic [LHT_ENTRIES-1:0][HIST_BITS-1:0] history_mem; // one history per branch entry

	logic [NUM_SLOTS-1:0][LHT_INDEX_BITS-1:0] fetch_index;
	logic [NUM_SLOTS-1:0][LHT_INDEX_BITS-1:0] resolve_index;
	logic same_entry; // both resolves land on one entry

	// outcome enters at the lsb, oldest bit falls off the top
	function automatic logic [HIST_BITS-1:0] shift_in(
		input logic [HIST_BITS-1:0] history,
		input logic                 taken
	);
		return {history[HIST_BITS-2:0], taken};
	endfunction

	always_comb begin
		for (int i = 0; i < NUM_SLOTS; i++) begin
			fetch_index[i] = fetch_pc[i][LHT_INDEX_BITS+PC_OFFSET_BITS-1:PC_OFFSET_BITS];
			resolve_index[i] = resolve[i].pc[LHT_INDEX_BITS+PC_OFFSET_BITS-1:PC_OFFSET_BITS];
			fetch_history[i] = history_mem[fetch_index[i]]; // pre-cycle value
			resolve_history[i] = history_mem[resolve_index[i]]; // pre-cycle value
		end
	end

	assign same_entry = resolve[0].valid && resolve[1].valid &&
		(resolve_index[0] == resolve_index[1]);

	always_ff @(posedge clock) begin
		if (reset) begin
			history_mem <= '0;
		end else if (same_entry) begin
			// slot 0 outcome first, then slot 1
			history_mem[resolve_index[0]] <=
				shift_in(shift_in(resolve_history[0], resolve[0].taken), resolve[1].taken);
		end else begin
			if (resolve[0].valid) begin
				history_mem[resolve_index[0]] <= shift_in(resolve_history[0], resolve[0].taken);
			end
			if (resolve[1].valid) begin
				history_mem[resolve_index[1]] <= shift_in(resolve_history[1], resolve[1].taken);
			end
		end
	end

	// history feeds the counter index and the mispredict flag downstream
	generate
		for (genvar g = 0; g < NUM_SLOTS; g++) begin : g_hist_known
			a_resolve_history_known: assert property (
				@(posedge clock) disable iff (reset)
				resolve[g].valid |-> !$isunknown(resolve_history[g])
			) else $error("resolve_history[%0d] unknown on a valid resolve", g);
		end
	endgenerate

endmodule

//--- local_predictor/pattern_counter_table.sv
`timescale 1ns/1ps

module pattern_counter_table
	import bp_config_pkg::*, bp_types_pkg::*;
(
	input  logic                                  clock,
	input  logic                                  reset,
	input  logic           [NUM_SLOTS-1:0][HIST_BITS-1:0] fetch_index,
	input  logic           [NUM_SLOTS-1:0][HIST_BITS-1:0] resolve_index,
	input  counter_write_t [NUM_SLOTS-1:0]                counter_write,
	output counter_state_e [NUM_SLOTS-1:0]                fetch_state,
	output counter_state_e [NUM_SLOTS-1:0]                resolve_state
);

	counter_state_e [PHT_ENTRIES-1:0] counter_mem; // indexed by local history

	// four combinational read ports, all see the pre-cycle table
	always_comb begin
		for (int i = 0; i < NUM_SLOTS; i++) begin
			fetch_state[i] = counter_mem[fetch_index[i]]; // prediction lookup
			resolve_state[i] = counter_mem[resolve_index[i]]; // mispredict and update lookup
		end
	end

	// two write ports, indices kept distinct by the resolve merge
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < PHT_ENTRIES; i++) begin
				counter_mem[i] <= STRONG_NT; // everything starts not-taken
			end
		end else begin
			for (int i = 0; i < NUM_SLOTS; i++) begin
				if (counter_write[i].en) begin
					counter_mem[counter_write[i].index] <= counter_write[i].state;
				end
			end
		end
	end

	// a shared counter must arrive as one merged write on slot 0
	a_no_write_collision: assert property (
		@(posedge clock) disable iff (reset)
		(counter_write[0].en && counter_write[1].en) |->
			(counter_write[0].index != counter_write[1].index)
	) else $error("both counter write ports hit index %0d", counter_write[0].index);

	// write data never carries x into the table
	generate
		for (genvar g = 0; g < NUM_SLOTS; g++) begin : g_write_known
			a_write_known: assert property (
				@(posedge clock) disable iff (reset)
				counter_write[g].en |-> !$isunknown({counter_write[g].index, counter_write[g].state})
			) else $error("counter write %0d carries unknown bits", g);
		end
	endgenerate

endmodule

//--- local_predictor/resolve_update.sv
`timescale 1ns/1ps

module resolve_update
	import bp_config_pkg::*, bp_types_pkg::*;
(
	input  resolve_slot_t  [NUM_SLOTS-1:0]                resolve,
	input  logic           [NUM_SLOTS-1:0][HIST_BITS-1:0] resolve_history,
	input  counter_state_e [NUM_SLOTS-1:0]                resolve_state,
	output counter_write_t [NUM_SLOTS-1:0]                counter_write,
	output mispredict_t    [NUM_SLOTS-1:0]                mispredict
);

	counter_state_e [NUM_SLOTS-1:0] stepped_state; // each slot on its own
	counter_state_e merged_state; // slot 0 step then slot 1 step
	logic same_counter; // both resolves train one counter

	// saturating step up on taken and down on not-taken
	function automatic counter_state_e step_counter(
		input counter_state_e state,
		input logic           taken
	);
		counter_state_e next_state;
		next_state = state;
		if (taken && (state != STRONG_T)) begin
			next_state = counter_state_e'(state + 2'd1);
		end else if (!taken && (state != STRONG_NT)) begin
			next_state = counter_state_e'(state - 2'd1);
		end
		return next_state;
	endfunction

	assign same_counter = resolve[0].valid && resolve[1].valid &&
		(resolve_history[0] == resolve_history[1]);

	always_comb begin
		for (int i = 0; i < NUM_SLOTS; i++) begin
			stepped_state[i] = step_counter(resolve_state[i], resolve[i].taken);
		end
		// same index means same pre-cycle state so chain from slot 0
		merged_state = step_counter(stepped_state[0], resolve[1].taken);
	end

	always_comb begin
		// slot 0 carries the merged value when the counter is shared
		counter_write[0].en = resolve[0].valid;
		counter_write[0].index = resolve_history[0];
		counter_write[0].state = same_counter ? merged_state : stepped_state[0];

		// slot 1 drops out on a shared counter
		counter_write[1].en = resolve[1].valid && !same_counter;
		counter_write[1].index = resolve_history[1];
		counter_write[1].state = stepped_state[1];
	end

	// flags come from the pre-cycle counter whose msb is the old prediction
	always_comb begin
		for (int i = 0; i < NUM_SLOTS; i++) begin
			mispredict[i].valid = resolve[i].valid; // not gated by the enable
			mispredict[i].mispredict = resolve[i].valid &&
				(resolve[i].taken != resolve_state[i][COUNTER_BITS-1]);
		end
	end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build the branch predictor testbench with Verilator and run it.

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_exe=sim_branch_predictor

verilator --binary --timing --assert -j 0 \
	-f build.f \
	--top-module tb_branch_predictor \
	-Mdir "$build_dir" \
	-o "$sim_exe"
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$("./$build_dir/$sim_exe" 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q -x "Finished with no errors" <<< "$output"; then
	exit 0
fi
echo "pass message not found in the simulation output"
exit 1

//--- sim/bp_model_tasks.svh
`ifndef BP_MODEL_TASKS_SVH
`define BP_MODEL_TASKS_SVH

logic [HIST_BITS-1:0] model_history [LHT_ENTRIES]; // mirror of the first level
int model_counter [PHT_ENTRIES]; // 0 strong not-taken .. 3 strong taken

task automatic model_reset();
	for (int i = 0; i < LHT_ENTRIES; i++) begin
		model_history[i] = '0; // all histories start empty
	end
	for (int i = 0; i < PHT_ENTRIES; i++) begin
		model_counter[i] = 0; // strong not-taken
	end
endtask

// history entry picked by pc[LHT_INDEX_BITS+1:2]
function automatic int model_entry(input logic [PC_WIDTH-1:0] pc);
	return int'(pc[LHT_INDEX_BITS+1:2]);
endfunction

function automatic prediction_t expected_prediction(input fetch_slot_t slot, input logic enable);
	prediction_t result;
	int ctr;
	ctr = model_counter[model_history[model_entry(slot.pc)]];
	result.valid = enable && slot.valid;
	result.taken = result.valid && (ctr >= 2); // upper half predicts taken
	return result;
endfunction

function automatic mispredict_t expected_mispredict(input resolve_slot_t slot);
	mispredict_t result;
	int ctr;
	ctr = model_counter[model_history[model_entry(slot.pc)]];
	result.valid = slot.valid; // enable plays no part here
	result.mispredict = slot.valid && (slot.taken != (ctr >= 2));
	return result;
endfunction

// both slots index with the old histories, then updates go slot 0 first
task automatic model_update(input resolve_slot_t [NUM_SLOTS-1:0] res);
	int ctr_index [NUM_SLOTS];
	int entry;
	for (int i = 0; i < NUM_SLOTS; i++) begin
		ctr_index[i] = int'(model_history[model_entry(res[i].pc)]);
	end
	for (int i = 0; i < NUM_SLOTS; i++) begin
		if (res[i].valid) begin
			entry = model_entry(res[i].pc);
			model_history[entry] = {model_history[entry][HIST_BITS-2:0], res[i].taken};
			if (res[i].taken && (model_counter[ctr_index[i]] < 3)) begin
				model_counter[ctr_index[i]]++;
			end else if (!res[i].taken && (model_counter[ctr_index[i]] > 0)) begin
				model_counter[ctr_index[i]]--;
			end
		end
	end
endtask

task automatic check_prediction(input string test_name, input int slot,
	input prediction_t expected, input prediction_t actual);
	check_count++;
	if (actual !== expected) begin
		error_count++;
		$display("ERROR %s slot %0d prediction: expected valid=%0b taken=%0b, actual valid=%0b taken=%0b",
			test_name, slot, expected.valid, expected.taken, actual.valid, actual.taken);
	end
endtask

task automatic check_mispredict(input string test_name, input int slot,
	input mispredict_t expected, input mispredict_t actual);
	check_count++;
	if (actual !== expected) begin
		error_count++;
		$display("ERROR %s slot %0d mispredict: expected valid=%0b flag=%0b, actual valid=%0b flag=%0b",
			test_name, slot, expected.valid, expected.mispredict, actual.valid, actual.mispredict);
	end
endtask

`endif

//--- sim/tb_branch_predictor.sv
`timescale 1ns/1ps

module tb_branch_predictor
	import bp_config_pkg::*, bp_types_pkg::*;
();

	logic clock;
	logic reset;
	logic predictor_enable;
	fetch_slot_t [NUM_SLOTS-1:0] fetch;
	resolve_slot_t [NUM_SLOTS-1:0] resolve;
	prediction_t [NUM_SLOTS-1:0] prediction;
	mispredict_t [NUM_SLOTS-1:0] mispredict;

	int error_count = 0;
	int check_count = 0;
	prediction_t [NUM_SLOTS-1:0] last_prediction; // sampled in the last cycle

	`include "bp_model_tasks.svh"

	branch_predictor u_branch_predictor (
		.clock            (clock),
		.reset            (reset),
		.predictor_enable (predictor_enable),
		.fetch            (fetch),
		.resolve          (resolve),
		.prediction       (prediction),
		.mispredict       (mispredict)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock; // 4 ns period
	end

	function automatic fetch_slot_t make_fetch(input logic valid, input logic [PC_WIDTH-1:0] pc);
		fetch_slot_t slot;
		slot.valid = valid;
		slot.pc = pc;
		return slot;
	endfunction

	function automatic resolve_slot_t make_resolve(input logic valid,
		input logic [PC_WIDTH-1:0] pc, input logic taken);
		resolve_slot_t slot;
		slot.valid = valid;
		slot.pc = pc;
		slot.taken = taken;
		return slot;
	endfunction

	// outputs are combinational, give them a bounded time to settle
	task automatic wait_outputs_known(input string test_name);
		int polls;
		polls = 0;
		#1;
		while ($isunknown({prediction, mispredict}) && (polls < 4)) begin
			#0.25;
			polls++;
		end
		if ($isunknown({prediction, mispredict})) begin
			error_count++;
			$display("%s: DUT outputs still unknown after the inputs were driven", test_name);
		end
	endtask

	// drive on the falling edge, check mid-cycle, then advance the model
	task automatic run_cycle(input string test_name, input logic enable,
		input fetch_slot_t [NUM_SLOTS-1:0] fetch_in,
		input resolve_slot_t [NUM_SLOTS-1:0] resolve_in);
		@(negedge clock);
		predictor_enable = enable;
		fetch = fetch_in;
		resolve = resolve_in;
		wait_outputs_known(test_name);
		last_prediction = prediction;
		for (int i = 0; i < NUM_SLOTS; i++) begin
			check_prediction(test_name, i, expected_prediction(fetch_in[i], enable), prediction[i]);
			check_mispredict(test_name, i, expected_mispredict(resolve_in[i]), mispredict[i]);
		end
		@(posedge clock);
		model_update(resolve_in); // dut tables move on this edge too
	endtask

	task automatic test_after_reset();
		fetch_slot_t [NUM_SLOTS-1:0] f;
		resolve_slot_t [NUM_SLOTS-1:0] r;
		f[0] = make_fetch(1'b1, 64'h100);
		f[1] = make_fetch(1'b1, 64'h104);
		r = '0;
		run_cycle("after_reset", 1'b1, f, r); // both not-taken
		f = '0;
		r[0] = make_resolve(1'b1, 64'h100, 1'b1); // taken against strong nt
		r[1] = make_resolve(1'b1, 64'h108, 1'b0);
		run_cycle("after_reset", 1'b1, f, r);
	endtask

	task automatic test_enable_low();
		fetch_slot_t [NUM_SLOTS-1:0] f;
		resolve_slot_t [NUM_SLOTS-1:0] r;
		f[0] = make_fetch(1'b1, 64'h10c);
		f[1] = make_fetch(1'b1, 64'h104);
		r = '0;
		r[0] = make_resolve(1'b1, 64'h10c, 1'b1);
		repeat (8) begin
			run_cycle("enable_low", 1'b0, f, r); // training goes on while gated
		end
		r = '0;
		run_cycle("enable_low", 1'b1, f, r);
	endtask

	task automatic test_counter_walk();
		fetch_slot_t [NUM_SLOTS-1:0] f;
		resolve_slot_t [NUM_SLOTS-1:0] r;
		f = '0;
		r = '0;
		f[0] = make_fetch(1'b1, 64'h110);
		r[0] = make_resolve(1'b1, 64'h110, 1'b1);
		repeat (10) begin
			run_cycle("counter_walk", 1'b1, f, r); // fetch sees the old state
		end
		r = '0;
		run_cycle("counter_walk", 1'b1, f, r);
		check_prediction("counter_walk", 0, prediction_t'{valid: 1'b1, taken: 1'b1},
			last_prediction[0]); // history all ones, counter now weak taken or above
	endtask

	task automatic test_alternating();
		fetch_slot_t [NUM_SLOTS-1:0] f;
		resolve_slot_t [NUM_SLOTS-1:0] r;
		f = '0;
		r = '0;
		f[1] = make_fetch(1'b1, 64'h114);
		for (int i = 0; i < 32; i++) begin
			r[0] = make_resolve(1'b1, 64'h114, i[0]); // 0,1,0,1 pattern
			run_cycle("alternating", 1'b1, f, r);
		end
	endtask

	task automatic test_dual_resolve();
		fetch_slot_t [NUM_SLOTS-1:0] f;
		resolve_slot_t [NUM_SLOTS-1:0] r;
		fetch_slot_t [NUM_SLOTS-1:0] no_fetch;
		resolve_slot_t [NUM_SLOTS-1:0] no_resolve;
		no_fetch = '0;
		no_resolve = '0;
		repeat (2) begin
			r[0] = make_resolve(1'b1, 64'h118, 1'b1); // same entry, other pc
			r[1] = make_resolve(1'b1, 64'h158, 1'b0);
			run_cycle("dual_same_entry", 1'b1, no_fetch, r);
			f[0] = make_fetch(1'b1, 64'h118);
			f[1] = make_fetch(1'b1, 64'h158);
			run_cycle("dual_same_entry", 1'b1, f, no_resolve);
			r[0] = make_resolve(1'b1, 64'h11c, 1'b1); // fresh entries share counter 0
			r[1] = make_resolve(1'b1, 64'h120, 1'b1);
			run_cycle("dual_same_counter", 1'b1, no_fetch, r);
			f[0] = make_fetch(1'b1, 64'h11c);
			f[1] = make_fetch(1'b1, 64'h120);
			run_cycle("dual_same_counter", 1'b1, f, no_resolve);
			r[0] = make_resolve(1'b1, 64'h110, 1'b1); // distinct entries and counters
			r[1] = make_resolve(1'b1, 64'h124, 1'b0);
			run_cycle("dual_distinct", 1'b1, no_fetch, r);
			f[0] = make_fetch(1'b1, 64'h110);
			f[1] = make_fetch(1'b1, 64'h124);
			run_cycle("dual_distinct", 1'b1, f, no_resolve);
		end
	endtask

	task automatic test_random_traffic();
		fetch_slot_t [NUM_SLOTS-1:0] f;
		resolve_slot_t [NUM_SLOTS-1:0] r;
		logic [PC_WIDTH-1:0] pc_set [4];
		logic enable;
		pc_set[0] = 64'h200;
		pc_set[1] = 64'h204;
		pc_set[2] = 64'h240; // aliases the entry of 0x200
		pc_set[3] = 64'h208;
		for (int n = 0; n < 200; n++) begin
			enable = ($urandom_range(0, 3) != 0);
			for (int i = 0; i < NUM_SLOTS; i++) begin
				f[i] = make_fetch(1'($urandom_range(0, 1)), pc_set[$urandom_range(0, 3)]);
				r[i] = make_resolve(1'($urandom_range(0, 1)), pc_set[$urandom_range(0, 3)],
					1'($urandom_range(0, 1)));
			end
			run_cycle("random_traffic", enable, f, r);
		end
	endtask

	initial begin
		void'($urandom(44)); // one seed for the whole run
		reset = 1'b1;
		predictor_enable = 1'b0;
		fetch = '0;
		resolve = '0;
		model_reset();
		repeat (8) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		test_after_reset();
		test_enable_low();
		test_counter_walk();
		test_alternating();
		test_dual_resolve();
		test_random_traffic();
		@(negedge clock);
		fetch = '0;
		resolve = '0;
		$display("%0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	// stops a run that never reaches the end of the test list
	initial begin
		repeat (2000) @(posedge clock);
		$display("timeout: the test sequence did not finish within 2000 cycles");
		$display("Finished with errors");
		$finish;
	end

endmodule
